/* rtl/decode.sv */
// Decode stage with operand select, hazard stall and the ID/EX latch
// Stalls on a dependence with the instruction in execute and holds after HALT
`default_nettype none

module decode import proc_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  instr_t     id_instr,
  input  word_t      id_pc_next,
  input  wire        redirect,
  input  wire        wb_en,
  input  reg_idx_t   wb_idx,
  input  word_t      wb_data,
  output logic       stall,
  output logic       ex_valid,
  output alu_func_t  ex_func,
  output word_t      ex_a,
  output word_t      ex_b,
  output word_t      ex_store_data,
  output word_t      ex_pc_next,
  output reg_idx_t   ex_rd,
  output logic       ex_reg_write,
  output logic       ex_mem_read,
  output logic       ex_mem_write,
  output logic       ex_beqz,
  output logic       ex_bnez,
  output logic       ex_halt,
  output logic       ex_illegal
);

  logic is_alu, is_addi, is_ld, is_st, is_beqz, is_bnez, is_halt, is_nop, illegal;
  logic uses_rs, uses_rt, reg_write, hazard, halt_hold, load_bubble;
  reg_idx_t rs, rt, dest;
  word_t rd_data_a, rd_data_b, imm_off, br_off, b_sel;

  assign rs = id_instr.i_form.rs;
  assign rt = id_instr.r_form.rt;

  reg_file reg_file_i (
    .clk       (clk),
    .reset     (reset),
    .rd_idx_a  (rs),
    .rd_idx_b  (rt),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (wb_en),
    .wr_idx    (wb_idx),
    .wr_data   (wb_data)
  );

  always_comb begin
    is_alu  = 1'b0;
    is_addi = 1'b0;
    is_ld   = 1'b0;
    is_st   = 1'b0;
    is_beqz = 1'b0;
    is_bnez = 1'b0;
    is_halt = 1'b0;
    is_nop  = 1'b0;
    illegal = 1'b0;
    case (id_instr.r_form.op)
      OP_HALT: is_halt = 1'b1;
      OP_NOP:  is_nop  = 1'b1;
      OP_ADDI: is_addi = 1'b1;
      OP_ST:   is_st   = 1'b1;
      OP_LD:   is_ld   = 1'b1;
      OP_ALU:  is_alu  = 1'b1;
      OP_BEQZ: is_beqz = 1'b1;
      OP_BNEZ: is_bnez = 1'b1;
      default: illegal = 1'b1;
    endcase
  end

  assign uses_rs   = is_alu | is_addi | is_ld | is_st | is_beqz | is_bnez;
  // ST keeps its data register in the rt slot
  assign uses_rt   = is_alu | is_st;
  assign reg_write = is_alu | is_addi | is_ld;
  assign dest      = is_alu ? id_instr.r_form.rd : id_instr.i_form.rd;

  assign imm_off = {{11{id_instr.i_form.imm5[4]}}, id_instr.i_form.imm5};
  // Word offset scaled to bytes
  assign br_off  = {{7{id_instr.b_form.imm8[7]}}, id_instr.b_form.imm8, 1'b0};
  assign b_sel   = is_alu ? rd_data_b : ((is_beqz | is_bnez) ? br_off : imm_off);

  // Writeback is covered by write-through so only ID/EX is checked
  assign hazard = ex_valid && ex_reg_write &&
                  ((uses_rs && (rs == ex_rd)) || (uses_rt && (rt == ex_rd)));
  assign stall       = hazard | halt_hold;
  assign load_bubble = stall | redirect;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid     <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_beqz      <= 1'b0;
      ex_bnez      <= 1'b0;
      ex_halt      <= 1'b0;
      ex_illegal   <= 1'b0;
      halt_hold    <= 1'b0;
    end else begin
      ex_valid     <= !load_bubble && !is_nop;
      ex_reg_write <= !load_bubble && reg_write;
      ex_mem_read  <= !load_bubble && is_ld;
      ex_mem_write <= !load_bubble && is_st;
      ex_beqz      <= !load_bubble && is_beqz;
      ex_bnez      <= !load_bubble && is_bnez;
      ex_halt      <= !load_bubble && is_halt;
      ex_illegal   <= !load_bubble && illegal;
      // Freeze the front end once HALT is issued
      if (redirect) begin
        halt_hold <= 1'b0;
      end else if (!load_bubble && is_halt) begin
        halt_hold <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    ex_func       <= is_alu ? id_instr.r_form.func : FN_ADD;
    ex_a          <= rd_data_a;
    ex_b          <= b_sel;
    ex_store_data <= rd_data_b;
    ex_pc_next    <= id_pc_next;
    ex_rd         <= dest;
  end

  // The fetch slot squashed by the redirect must not issue either
  a_squash_after_redirect: assert property (@(posedge clk) disable iff (reset)
    $past(redirect, 2) |-> !ex_valid)
    else $error("decode: instruction issued from a squashed fetch slot");

endmodule

`default_nettype wire

/* rtl/execute.sv */
// Execute stage with the ALU, branch resolution and the EX/MW latch
// A taken branch redirects fetch for one cycle and an illegal opcode sets a sticky err
`default_nettype none

module execute import proc_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire        ex_valid,
  input  alu_func_t  ex_func,
  input  word_t      ex_a,
  input  word_t      ex_b,
  input  word_t      ex_store_data,
  input  word_t      ex_pc_next,
  input  reg_idx_t   ex_rd,
  input  wire        ex_reg_write,
  input  wire        ex_mem_read,
  input  wire        ex_mem_write,
  input  wire        ex_beqz,
  input  wire        ex_bnez,
  input  wire        ex_halt,
  input  wire        ex_illegal,
  output logic       redirect,
  output word_t      redirect_pc,
  output logic       err,
  output logic       mw_valid,
  output word_t      mw_result,
  output word_t      mw_store_data,
  output reg_idx_t   mw_rd,
  output logic       mw_reg_write,
  output logic       mw_mem_read,
  output logic       mw_mem_write,
  output logic       mw_halt
);

  word_t result;
  logic  a_zero;

  // Non-ALU ops arrive with FN_ADD to form the address or ADDI sum
  always_comb begin
    case (ex_func)
      FN_ADD:  result = ex_a + ex_b;
      FN_SUB:  result = ex_a - ex_b;
      FN_XOR:  result = ex_a ^ ex_b;
      FN_AND:  result = ex_a & ex_b;
      default: result = ex_a + ex_b;
    endcase
  end

  assign a_zero      = (ex_a == '0);
  assign redirect    = ex_valid && ((ex_beqz && a_zero) || (ex_bnez && !a_zero));
  assign redirect_pc = ex_pc_next + ex_b;

  always_ff @(posedge clk) begin
    if (reset) begin
      err <= 1'b0;
    end else if (ex_valid && ex_illegal) begin
      err <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mw_valid     <= 1'b0;
      mw_reg_write <= 1'b0;
      mw_mem_read  <= 1'b0;
      mw_mem_write <= 1'b0;
      mw_halt      <= 1'b0;
    end else begin
      mw_valid     <= ex_valid;
      mw_reg_write <= ex_valid && ex_reg_write;
      mw_mem_read  <= ex_valid && ex_mem_read;
      mw_mem_write <= ex_valid && ex_mem_write;
      mw_halt      <= ex_valid && ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    mw_result     <= result;
    mw_store_data <= ex_store_data;
    mw_rd         <= ex_rd;
  end

  // Squash in decode must turn the redirect into a single pulse
  a_redirect_pulse: assert property (@(posedge clk) disable iff (reset)
    redirect |=> !redirect)
    else $error("execute: redirect longer than one cycle");

endmodule

`default_nettype wire

/* rtl/fetch.sv */
// Fetch stage with the PC register and IF/ID latch
// Holds on a decode stall, squashes and reloads the PC on an execute redirect
`default_nettype none

module fetch import proc_pkg::*; #(
  parameter word_t START_PC = 16'h0000
) (
  input  wire         clk,
  input  wire         reset,
  input  wire         stall,
  input  wire         redirect,
  input  word_t       redirect_pc,
  output word_t       imem_addr,
  input  instr_t      imem_data,
  output instr_t      id_instr,
  output word_t       id_pc_next
);

  word_t pc;
  word_t pc_plus_2;

  assign imem_addr = pc;
  assign pc_plus_2 = pc + 16'd2;

  // Redirect takes priority over a stall
  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= START_PC;
      id_instr <= NOP_INSTR;
    end else if (redirect) begin
      pc       <= redirect_pc;
      id_instr <= NOP_INSTR;
    end else if (!stall) begin
      pc       <= pc_plus_2;
      id_instr <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && !redirect) begin
      id_pc_next <= pc_plus_2;
    end
  end

  // Start address and branch targets keep the PC halfword aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    !imem_addr[0])
    else $error("fetch: PC is not halfword aligned");

endmodule

`default_nettype wire

/* rtl/mem_writeback.sv */
// Memory and writeback stage: data memory, result select, register write
// Reports each register write as a commit and keeps a sticky halt
`default_nettype none

module mem_writeback import proc_pkg::*; #(
  parameter int DMEM_WORDS = 256
) (
  input  wire        clk,
  input  wire        reset,
  input  wire        mw_valid,
  input  word_t      mw_result,
  input  word_t      mw_store_data,
  input  reg_idx_t   mw_rd,
  input  wire        mw_reg_write,
  input  wire        mw_mem_read,
  input  wire        mw_mem_write,
  input  wire        mw_halt,
  output logic       wb_en,
  output reg_idx_t   wb_idx,
  output word_t      wb_data,
  output logic       commit_valid,
  output reg_idx_t   commit_reg,
  output word_t      commit_data,
  output logic       halt
);

  localparam int AW = $clog2(DMEM_WORDS);

  word_t          dmem [DMEM_WORDS];
  logic [AW-1:0]  dmem_addr;
  word_t          load_data;

  // Byte address, word-sized memory
  assign dmem_addr = mw_result[AW:1];
  assign load_data = dmem[dmem_addr];

  always_ff @(posedge clk) begin
    if (mw_valid && mw_mem_write) begin
      dmem[dmem_addr] <= mw_store_data;
    end
  end

  assign wb_en   = mw_valid && mw_reg_write;
  assign wb_idx  = mw_rd;
  assign wb_data = mw_mem_read ? load_data : mw_result;

  assign commit_valid = wb_en;
  assign commit_reg   = wb_idx;
  assign commit_data  = wb_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      halt <= 1'b0;
    end else if (mw_valid && mw_halt) begin
      halt <= 1'b1;
    end
  end

  a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(mw_mem_read && mw_mem_write))
    else $error("mem_writeback: load and store in the same slot");

endmodule

`default_nettype wire

/* rtl/proc.sv */
// Top level of the four-stage pipelined processor
// Connects fetch, decode, execute and memory/writeback
`default_nettype none

module proc import proc_pkg::*; #(
  parameter word_t START_PC   = 16'h0000,
  parameter int    DMEM_WORDS = 256
) (
  input  wire       clk,
  input  wire       reset,
  output word_t     imem_addr,
  input  instr_t    imem_data,
  output logic      commit_valid,
  output reg_idx_t  commit_reg,
  output word_t     commit_data,
  output logic      halt,
  output logic      err
);

  // IF/ID and control back to fetch
  instr_t    id_instr;
  word_t     id_pc_next, redirect_pc;
  logic      stall, redirect;

  // ID/EX
  logic      ex_valid, ex_reg_write, ex_mem_read, ex_mem_write;
  logic      ex_beqz, ex_bnez, ex_halt, ex_illegal;
  alu_func_t ex_func;
  word_t     ex_a, ex_b, ex_store_data, ex_pc_next;
  reg_idx_t  ex_rd;

  // EX/MW and writeback
  logic      mw_valid, mw_reg_write, mw_mem_read, mw_mem_write, mw_halt;
  word_t     mw_result, mw_store_data, wb_data;
  reg_idx_t  mw_rd, wb_idx;
  logic      wb_en;

  fetch #(.START_PC(START_PC)) fetch_i (
    .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
    .redirect_pc(redirect_pc), .imem_addr(imem_addr), .imem_data(imem_data),
    .id_instr(id_instr), .id_pc_next(id_pc_next)
  );

  decode decode_i (
    .clk(clk), .reset(reset), .id_instr(id_instr), .id_pc_next(id_pc_next),
    .redirect(redirect), .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data),
    .stall(stall), .ex_valid(ex_valid), .ex_func(ex_func), .ex_a(ex_a), .ex_b(ex_b),
    .ex_store_data(ex_store_data), .ex_pc_next(ex_pc_next), .ex_rd(ex_rd),
    .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
    .ex_mem_write(ex_mem_write), .ex_beqz(ex_beqz), .ex_bnez(ex_bnez),
    .ex_halt(ex_halt), .ex_illegal(ex_illegal)
  );

  execute execute_i (
    .clk(clk), .reset(reset), .ex_valid(ex_valid), .ex_func(ex_func),
    .ex_a(ex_a), .ex_b(ex_b), .ex_store_data(ex_store_data), .ex_pc_next(ex_pc_next),
    .ex_rd(ex_rd), .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
    .ex_mem_write(ex_mem_write), .ex_beqz(ex_beqz), .ex_bnez(ex_bnez),
    .ex_halt(ex_halt), .ex_illegal(ex_illegal), .redirect(redirect),
    .redirect_pc(redirect_pc), .err(err), .mw_valid(mw_valid), .mw_result(mw_result),
    .mw_store_data(mw_store_data), .mw_rd(mw_rd), .mw_reg_write(mw_reg_write),
    .mw_mem_read(mw_mem_read), .mw_mem_write(mw_mem_write), .mw_halt(mw_halt)
  );

  mem_writeback #(.DMEM_WORDS(DMEM_WORDS)) mem_writeback_i (
    .clk(clk), .reset(reset), .mw_valid(mw_valid), .mw_result(mw_result),
    .mw_store_data(mw_store_data), .mw_rd(mw_rd), .mw_reg_write(mw_reg_write),
    .mw_mem_read(mw_mem_read), .mw_mem_write(mw_mem_write), .mw_halt(mw_halt),
    .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data), .commit_valid(commit_valid),
    .commit_reg(commit_reg), .commit_data(commit_data), .halt(halt)
  );

endmodule

`default_nettype wire

/* rtl/proc_pkg.sv */
// Shared types for the 16-bit four-stage pipelined processor
// Word, register index, opcode and ALU function types, plus the instruction union
`default_nettype none

package proc_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  reg_idx_t;

  typedef enum logic [4:0] {
    OP_HALT = 5'b00000,
    OP_NOP  = 5'b00001,
    OP_ADDI = 5'b01000,
    OP_BEQZ = 5'b01100,
    OP_BNEZ = 5'b01101,
    OP_ST   = 5'b10000,
    OP_LD   = 5'b10001,
    OP_ALU  = 5'b11011
  } opcode_t;

  typedef enum logic [1:0] {
    FN_ADD = 2'b00,
    FN_SUB = 2'b01,
    FN_XOR = 2'b10,
    FN_AND = 2'b11
  } alu_func_t;

  // One instruction word, three field layouts
  typedef union packed {
    struct packed {
      opcode_t   op;
      reg_idx_t  rs;
      reg_idx_t  rt;
      reg_idx_t  rd;
      alu_func_t func;
    } r_form;
    struct packed {
      opcode_t    op;
      reg_idx_t   rs;
      reg_idx_t   rd;
      logic [4:0] imm5;
    } i_form;
    struct packed {
      opcode_t    op;
      reg_idx_t   rs;
      logic [7:0] imm8;
    } b_form;
  } instr_t;

  // Bubble encoding, a NOP with all other fields zero
  localparam instr_t NOP_INSTR = instr_t'(16'h0800);

endpackage

`default_nettype wire

/* rtl/reg_file.sv */
// Register file, eight 16-bit registers
// Two read ports, one write port, reads see a same-cycle write
`default_nettype none

module reg_file import proc_pkg::*; (
  input  wire       clk,
  input  wire       reset,
  input  reg_idx_t  rd_idx_a,
  input  reg_idx_t  rd_idx_b,
  output word_t     rd_data_a,
  output word_t     rd_data_b,
  input  wire       wr_en,
  input  reg_idx_t  wr_idx,
  input  word_t     wr_data
);

  word_t regs [8];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Write-through so the writeback stage needs no hazard check
  assign rd_data_a = (wr_en && (wr_idx == rd_idx_a)) ? wr_data : regs[rd_idx_a];
  assign rd_data_b = (wr_en && (wr_idx == rd_idx_b)) ? wr_data : regs[rd_idx_b];

  a_wr_idx_known: assert property (@(posedge clk) disable iff (reset)
    wr_en |-> !$isunknown(wr_idx))
    else $error("reg_file: write index unknown");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module proc_tb -o proc_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/proc_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation finished without failures"
exit 0

/* sources.f */
rtl/proc_pkg.sv
rtl/fetch.sv
rtl/reg_file.sv
rtl/decode.sv
rtl/execute.sv
rtl/mem_writeback.sv
rtl/proc.sv
testbench/proc_tb.sv

/* testbench/proc_tb.sv */
// Testbench for the pipelined processor
// Plays instruction memory from a program table and checks the commit trace
`default_nettype none

module proc_tb import proc_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS = 6;
  localparam int MAX_LEN = 16;
  localparam word_t START = 16'h0000;

  logic     clk;
  logic     reset;
  word_t    imem_addr;
  instr_t   imem_data;
  logic     commit_valid;
  reg_idx_t commit_reg;
  word_t    commit_data;
  logic     halt;
  logic     err;

  // Program table with expected commits per test
  instr_t   prog [NUM_TESTS][MAX_LEN];
  int       prog_len [NUM_TESTS];
  reg_idx_t exp_reg [NUM_TESTS][MAX_LEN];
  word_t    exp_data [NUM_TESTS][MAX_LEN];
  int       n_exp [NUM_TESTS];
  logic     exp_err [NUM_TESTS];
  int       cur_test;

  proc #(.START_PC(START), .DMEM_WORDS(256)) proc_i (
    .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
    .commit_valid(commit_valid), .commit_reg(commit_reg), .commit_data(commit_data),
    .halt(halt), .err(err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("** Error: %s = 0x%h, expected 0x%h in test %0d",
                                  name, got, exp, cur_test));
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("** Error: %s = 0x%h, expected 0x%h in test %0d",
                                  name, got, exp, cur_test));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("** Error: %s = 0x%h, expected 0x%h in test %0d",
                                  name, got, exp, cur_test));
    end
  endtask

  // Instruction encoders for the ISA field layouts
  function automatic instr_t enc_alu(alu_func_t fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
    instr_t w;
    w.r_form.op   = OP_ALU;
    w.r_form.rs   = rs;
    w.r_form.rt   = rt;
    w.r_form.rd   = rd;
    w.r_form.func = fn;
    return w;
  endfunction

  // For ST the rd field names the data register
  function automatic instr_t enc_imm(opcode_t op, reg_idx_t rd, reg_idx_t rs, logic [4:0] imm);
    instr_t w;
    w.i_form.op   = op;
    w.i_form.rs   = rs;
    w.i_form.rd   = rd;
    w.i_form.imm5 = imm;
    return w;
  endfunction

  function automatic instr_t enc_br(opcode_t op, reg_idx_t rs, logic [7:0] off);
    instr_t w;
    w.b_form.op   = op;
    w.b_form.rs   = rs;
    w.b_form.imm8 = off;
    return w;
  endfunction

  function automatic instr_t enc_bare(logic [4:0] op);
    return instr_t'({op, 11'b0});
  endfunction

  function automatic word_t sext5(logic [4:0] v);
    return {{11{v[4]}}, v};
  endfunction

  task automatic add_instr(input int t, input instr_t w);
    prog[t][prog_len[t]] = w;
    prog_len[t]++;
  endtask

  task automatic add_commit(input int t, input reg_idx_t r, input word_t d);
    exp_reg[t][n_exp[t]]  = r;
    exp_data[t][n_exp[t]] = d;
    n_exp[t]++;
  endtask

  task automatic build_table();
    logic [4:0] i1;
    logic [4:0] i2;
    word_t      s1;
    word_t      s2;
    i1 = 5'($urandom);
    i2 = 5'($urandom);
    s1 = sext5(i1);
    s2 = sext5(i2);
    for (int t = 0; t < NUM_TESTS; t++) begin
      prog_len[t] = 0;
      n_exp[t]    = 0;
      exp_err[t]  = 1'b0;
      for (int i = 0; i < MAX_LEN; i++) begin
        prog[t][i] = NOP_INSTR;
      end
    end
    // Test 0 covers ADDI and the four independent ALU functions
    add_instr(0, enc_imm(OP_ADDI, 3'd1, 3'd0, i1));
    add_instr(0, enc_imm(OP_ADDI, 3'd2, 3'd0, i2));
    add_instr(0, enc_bare(OP_NOP));
    add_instr(0, enc_alu(FN_ADD, 3'd3, 3'd1, 3'd2));
    add_instr(0, enc_alu(FN_SUB, 3'd4, 3'd1, 3'd2));
    add_instr(0, enc_alu(FN_XOR, 3'd5, 3'd1, 3'd2));
    add_instr(0, enc_alu(FN_AND, 3'd6, 3'd1, 3'd2));
    add_instr(0, enc_bare(OP_HALT));
    add_commit(0, 3'd1, s1);
    add_commit(0, 3'd2, s2);
    add_commit(0, 3'd3, s1 + s2);
    add_commit(0, 3'd4, s1 - s2);
    add_commit(0, 3'd5, s1 ^ s2);
    add_commit(0, 3'd6, s1 & s2);
    // Test 1 has back-to-back dependences and a load followed by its use
    add_instr(1, enc_imm(OP_ADDI, 3'd1, 3'd0, 5'd7));
    add_instr(1, enc_imm(OP_ADDI, 3'd2, 3'd1, 5'd3));
    add_instr(1, enc_alu(FN_ADD, 3'd3, 3'd2, 3'd1));
    add_instr(1, enc_imm(OP_ST, 3'd3, 3'd0, 5'd2));
    add_instr(1, enc_imm(OP_LD, 3'd4, 3'd0, 5'd2));
    add_instr(1, enc_imm(OP_ADDI, 3'd5, 3'd4, 5'd1));
    add_instr(1, enc_alu(FN_SUB, 3'd6, 3'd5, 3'd4));
    add_instr(1, enc_bare(OP_HALT));
    add_commit(1, 3'd1, 16'd7);
    add_commit(1, 3'd2, 16'd10);
    add_commit(1, 3'd3, 16'd17);
    add_commit(1, 3'd4, 16'd17);
    add_commit(1, 3'd5, 16'd18);
    add_commit(1, 3'd6, 16'd1);
    // Test 2 stores then loads through computed addresses with imm 5'h1b as -5
    add_instr(2, enc_imm(OP_ADDI, 3'd1, 3'd0, 5'd10));
    add_instr(2, enc_imm(OP_ADDI, 3'd2, 3'd0, 5'h1b));
    add_instr(2, enc_imm(OP_ST, 3'd2, 3'd1, 5'd4));
    add_instr(2, enc_imm(OP_LD, 3'd3, 3'd1, 5'd4));
    add_instr(2, enc_imm(OP_ADDI, 3'd4, 3'd1, 5'd6));
    add_instr(2, enc_imm(OP_LD, 3'd5, 3'd4, 5'h1e));
    add_instr(2, enc_bare(OP_HALT));
    add_commit(2, 3'd1, 16'd10);
    add_commit(2, 3'd2, 16'hfffb);
    add_commit(2, 3'd3, 16'hfffb);
    add_commit(2, 3'd4, 16'd16);
    add_commit(2, 3'd5, 16'hfffb);
    // Test 3 has a taken BEQZ, an untaken BNEZ and a three-pass loop
    add_instr(3, enc_br(OP_BEQZ, 3'd0, 8'd2));
    add_instr(3, enc_imm(OP_ADDI, 3'd7, 3'd0, 5'd1));
    add_instr(3, enc_imm(OP_ADDI, 3'd7, 3'd0, 5'd2));
    add_instr(3, enc_imm(OP_ADDI, 3'd1, 3'd0, 5'd3));
    add_instr(3, enc_br(OP_BNEZ, 3'd0, 8'd5));
    add_instr(3, enc_imm(OP_ADDI, 3'd2, 3'd2, 5'd2));
    add_instr(3, enc_imm(OP_ADDI, 3'd1, 3'd1, 5'h1f));
    add_instr(3, enc_br(OP_BNEZ, 3'd1, 8'hfd));
    add_instr(3, enc_bare(OP_HALT));
    add_commit(3, 3'd1, 16'd3);
    for (int k = 1; k <= 3; k++) begin
      add_commit(3, 3'd2, word_t'(2 * k));
      add_commit(3, 3'd1, word_t'(3 - k));
    end
    // Test 4 checks that HALT stops everything behind it
    add_instr(4, enc_imm(OP_ADDI, 3'd1, 3'd0, 5'd1));
    add_instr(4, enc_bare(OP_HALT));
    add_instr(4, enc_imm(OP_ADDI, 3'd2, 3'd0, 5'd2));
    add_instr(4, enc_imm(OP_ADDI, 3'd3, 3'd0, 5'd3));
    add_commit(4, 3'd1, 16'd1);
    // Test 5 ends on an illegal opcode
    add_instr(5, enc_imm(OP_ADDI, 3'd1, 3'd0, 5'd9));
    add_instr(5, enc_bare(5'b11111));
    add_commit(5, 3'd1, 16'd9);
    exp_err[5] = 1'b1;
  endtask

  // Instruction memory answers a short delay after each rising edge
  initial begin
    word_t widx;
    imem_data = NOP_INSTR;
    forever begin
      @(posedge clk);
      #1;
      widx = (imem_addr - START) >> 1;
      if (widx < 16'd16) begin
        imem_data = prog[cur_test][widx[3:0]];
      end else begin
        imem_data = NOP_INSTR;
      end
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic run_test(input int t);
    int n_seen;
    n_seen = 0;
    cur_test = t;
    apply_reset();
    // Fetch starts from the reset PC
    check_word("imem_addr", imem_addr, START);
    do begin
      @(negedge clk);
      if (commit_valid) begin
        if (n_seen >= n_exp[t]) begin
          stop_with_failure($sformatf("Test %0d committed more results than expected", t));
        end
        check_reg("commit_reg", commit_reg, exp_reg[t][n_seen]);
        check_word("commit_data", commit_data, exp_data[t][n_seen]);
        n_seen++;
      end
    end while (!halt && !err);
    if (n_seen != n_exp[t]) begin
      stop_with_failure($sformatf("Test %0d stopped after %0d of %0d expected commits",
                                  t, n_seen, n_exp[t]));
    end
    // Pipeline must stay quiet and the flags must hold
    repeat (5) begin
      @(negedge clk);
      if (commit_valid) begin
        stop_with_failure($sformatf("Test %0d committed a result after halt or err", t));
      end
      check_bit("err", err, exp_err[t]);
      check_bit("halt", halt, !exp_err[t]);
    end
  endtask

  initial begin
    #(NUM_TESTS * 200 * 10);
    stop_with_failure("Timeout: the run did not finish in the allowed time");
  end

  initial begin
    reset = 1'b1;
    cur_test = 0;
    void'($urandom(4));
    build_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
